// File: dv/tb_wb_subsystem.sv
`include "wb_defs.svh"

module tb_wb_subsystem;

    timeunit 1ns;
    timeprecision 100ps;

    import wb_pkg::*;

    logic        clk, rst_n, in_valid;
    xlen_t       in_pc, in_alu_out, in_csr_out, in_rdata;
    inst_t       in_inst;
    logic        in_write_gpr, in_write_csr_1, in_write_csr_2, in_mem_to_reg, in_halt;
    gpr_addr_t   in_rd, rs1_addr, rs2_addr;
    csr_addr_t   in_csr_rd_1, in_csr_rd_2, csr_raddr;
    xlen_t       rs1_data, rs2_data, csr_rdata, commit_pc;
    inst_t       commit_inst;
    logic        commit, halted;
    logic [63:0] instret;

    // reference model state
    wb_bundle_t  st;
    logic        st_valid, halt_m;
    logic [63:0] instret_m;
    xlen_t       gpr_m [32];
    xlen_t       csr_m [5];
    logic        m_commit, m_gwe, m_we1, m_we2;
    xlen_t       m_gdata, m_rs1, m_rs2, m_csr;

    // stimulus bookkeeping
    string       test_name;
    int          errs, total_errs, tests_run, tests_failed;
    logic [63:0] n_retired;
    logic        halt_sent;
    gpr_addr_t   last_rd;
    csr_addr_t   last_c1, last_c2;

    wb_subsystem dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // five mapped csrs first, then two unmapped ones
    function automatic csr_addr_t csr_pick(input int sel);
        csr_addr_t a;
        case (sel)
            0:       a = `WB_CSR_MSTATUS;
            1:       a = `WB_CSR_MTVEC;
            2:       a = `WB_CSR_MSCRATCH;
            3:       a = `WB_CSR_MEPC;
            4:       a = `WB_CSR_MCAUSE;
            5:       a = 12'h7c0;
            default: a = 12'h001;
        endcase
        return a;
    endfunction

    function automatic int csr_slot(input csr_addr_t a);
        int s;
        s = -1;
        for (int k = 0; k < 5; k++) begin
            if (csr_pick(k) == a) s = k;
        end
        return s;
    endfunction

    // ==================================================================
    // reference model
    // ==================================================================
    function automatic xlen_t gpr_expect(input gpr_addr_t a);
        xlen_t d;
        if (a == '0) d = '0;
        else if (m_gwe && st.rd == a) d = m_gdata;
        else d = gpr_m[a];
        return d;
    endfunction

    // port 2 beats port 1 on a shared target
    function automatic xlen_t csr_expect(input csr_addr_t a);
        xlen_t d;
        if (csr_slot(a) < 0) d = '0;
        else if (m_we2 && st.csr_rd_2 == a) d = st.pc;
        else if (m_we1 && st.csr_rd_1 == a) d = st.csr_out;
        else d = csr_m[csr_slot(a)];
        return d;
    endfunction

    always_comb begin
        m_commit = st_valid && !halt_m;
        m_gwe    = m_commit && st.write_gpr;
        m_we1    = m_commit && st.write_csr_1;
        m_we2    = m_commit && st.write_csr_2;
        m_gdata  = st.mem_to_reg ? st.rdata : st.alu_out;
        m_rs1    = gpr_expect(rs1_addr);
        m_rs2    = gpr_expect(rs2_addr);
        m_csr    = csr_expect(csr_raddr);
    end

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            st_valid  <= 1'b0;
            st        <= '0;
            halt_m    <= 1'b0;
            instret_m <= '0;
            for (int i = 0; i < 32; i++) gpr_m[i] <= '0;
            for (int i = 0; i < 5; i++) csr_m[i] <= '0;
        end else begin
            st_valid <= in_valid;
            if (in_valid) begin
                st <= '{in_pc, in_inst, in_alu_out, in_csr_out, in_rdata, in_write_gpr,
                        in_write_csr_1, in_write_csr_2, in_mem_to_reg, in_rd,
                        in_csr_rd_1, in_csr_rd_2, in_halt};
            end
            if (m_commit) begin
                instret_m <= instret_m + 64'd1;
                if (st.halt) halt_m <= 1'b1;
                if (m_gwe && st.rd != '0) gpr_m[st.rd] <= m_gdata;
                if (m_we1 && csr_slot(st.csr_rd_1) >= 0) begin
                    csr_m[csr_slot(st.csr_rd_1)] <= st.csr_out;
                end
                // later assignment models the port 2 priority
                if (m_we2 && csr_slot(st.csr_rd_2) >= 0) csr_m[csr_slot(st.csr_rd_2)] <= st.pc;
            end
        end
    end

    task automatic report_value(input string what, input logic [63:0] expv,
                                input logic [63:0] actv);
        $display("FAILED %s %s: expected %h, actual %h", test_name, what, expv, actv);
        errs++;
        total_errs++;
    endtask

    // ==================================================================
    // checks
    // ==================================================================
    a_commit: assert property (@(posedge clk) disable iff (!rst_n) commit == m_commit)
        else report_value("commit", $sampled(m_commit), $sampled(commit));
    a_pc: assert property (@(posedge clk) disable iff (!rst_n) m_commit |-> (commit_pc == st.pc))
        else report_value("commit_pc", $sampled(st.pc), $sampled(commit_pc));
    a_inst: assert property (@(posedge clk) disable iff (!rst_n)
                             m_commit |-> (commit_inst == st.inst))
        else report_value("commit_inst", $sampled(st.inst), $sampled(commit_inst));
    a_rs1: assert property (@(posedge clk) disable iff (!rst_n) rs1_data == m_rs1)
        else report_value("rs1_data", $sampled(m_rs1), $sampled(rs1_data));
    a_rs2: assert property (@(posedge clk) disable iff (!rst_n) rs2_data == m_rs2)
        else report_value("rs2_data", $sampled(m_rs2), $sampled(rs2_data));
    a_csr: assert property (@(posedge clk) disable iff (!rst_n) csr_rdata == m_csr)
        else report_value("csr_rdata", $sampled(m_csr), $sampled(csr_rdata));
    a_halted: assert property (@(posedge clk) disable iff (!rst_n) halted == halt_m)
        else report_value("halted", $sampled(halt_m), $sampled(halted));
    a_instret: assert property (@(posedge clk) disable iff (!rst_n) instret == instret_m)
        else report_value("instret", $sampled(instret_m), $sampled(instret));

    // point the read ports at the item now committing
    task automatic set_reads();
        rs1_addr  = last_rd;
        rs2_addr  = last_rd;
        csr_raddr = ($urandom % 2 == 0) ? last_c1 : last_c2;
    endtask

    task automatic send_item(input logic wgpr, input logic wc1, input logic wc2,
                             input logic hlt, input gpr_addr_t rd,
                             input csr_addr_t c1, input csr_addr_t c2);
        @(negedge clk);
        set_reads();
        in_valid       = 1'b1;
        in_pc          = $urandom & 32'hffff_fffc;
        in_inst        = $urandom;
        in_alu_out     = $urandom;
        in_csr_out     = $urandom;
        in_rdata       = $urandom;
        in_mem_to_reg  = 1'($urandom);
        in_write_gpr   = wgpr;
        in_write_csr_1 = wc1;
        in_write_csr_2 = wc2;
        in_halt        = hlt;
        in_rd          = rd;
        in_csr_rd_1    = c1;
        in_csr_rd_2    = c2;
        last_rd        = rd;
        last_c1        = c1;
        last_c2        = c2;
        if (!halt_sent) n_retired++;
        if (hlt) halt_sent = 1'b1;
    endtask

    task automatic idle_cycle();
        @(negedge clk);
        set_reads();
        in_valid = 1'b0;
    endtask

    task automatic sweep_reads();
        for (int i = 0; i < 16; i++) begin
            @(negedge clk);
            in_valid  = 1'b0;
            rs1_addr  = gpr_addr_t'(i);
            rs2_addr  = gpr_addr_t'(i + 16);
            csr_raddr = csr_pick(i % 7);
        end
    endtask

    task automatic check_retired();
        assert (instret == n_retired)
            else report_value("retired count", n_retired, instret);
    endtask

    task automatic wait_halted();
        logic seen;
        seen = 1'b0;
        for (int i = 0; i < 8 && !seen; i++) begin
            idle_cycle();
            seen = halted;
        end
        if (!seen) begin
            $display("timeout in %s: halted did not rise after the halt bundle", test_name);
            errs++;
            total_errs++;
        end
    endtask

    task automatic start_test(input string name);
        test_name = name;
        errs      = 0;
    endtask

    task automatic finish_test();
        tests_run++;
        if (errs == 0) begin
            $display("test %s: ok", test_name);
        end else begin
            $display("test %s: %0d errors", test_name, errs);
            tests_failed++;
        end
    endtask

    // ==================================================================
    // test sequence
    // ==================================================================
    initial begin
        csr_addr_t c1;
        void'($urandom(32'h38dc421b));
        {rst_n, in_valid, in_write_gpr, in_write_csr_1, in_write_csr_2} = '0;
        {in_mem_to_reg, in_halt, halt_sent} = '0;
        {in_pc, in_inst, in_alu_out, in_csr_out, in_rdata} = '0;
        {in_rd, rs1_addr, rs2_addr, last_rd} = '0;
        {in_csr_rd_1, in_csr_rd_2, csr_raddr, last_c1, last_c2} = '0;
        {errs, total_errs, tests_run, tests_failed} = '0;
        n_retired = '0;
        start_test("reset");
        for (int i = 0; i < 5; i++) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        sweep_reads();
        check_retired();
        finish_test();

        // x0 gets every eighth write
        start_test("gpr_random");
        for (int i = 0; i < 40; i++) begin
            send_item(1'b1, 1'b0, 1'b0, 1'b0, (i % 8 == 0) ? '0 : gpr_addr_t'($urandom),
                      csr_pick(0), csr_pick(0));
            if ($urandom % 3 == 0) idle_cycle();
        end
        idle_cycle();
        sweep_reads();
        check_retired();
        finish_test();

        start_test("csr_write");
        for (int i = 0; i < 40; i++) begin
            c1 = csr_pick($urandom % 7);
            send_item(1'($urandom), 1'b1, 1'b1, 1'b0, gpr_addr_t'($urandom), c1,
                      (i % 4 == 0) ? c1 : csr_pick($urandom % 7));
            if ($urandom % 3 == 0) idle_cycle();
        end
        idle_cycle();
        sweep_reads();
        check_retired();
        finish_test();

        start_test("back_to_back");
        for (int i = 0; i < 24; i++) begin
            send_item(1'b1, 1'($urandom), 1'b0, 1'b0, gpr_addr_t'($urandom),
                      csr_pick($urandom % 5), csr_pick(0));
        end
        idle_cycle();
        sweep_reads();
        check_retired();
        finish_test();

        // bundles after the halting one must leave no trace
        start_test("halt");
        for (int i = 0; i < 3; i++) begin
            send_item(1'b1, 1'b1, 1'b0, 1'b0, gpr_addr_t'($urandom), csr_pick(2), csr_pick(0));
        end
        send_item(1'b1, 1'b1, 1'b1, 1'b1, 5'd7, csr_pick(4), csr_pick(3));
        wait_halted();
        for (int i = 0; i < 10; i++) begin
            send_item(1'b1, 1'b1, 1'b1, 1'($urandom), gpr_addr_t'($urandom),
                      csr_pick($urandom % 5), csr_pick($urandom % 5));
        end
        idle_cycle();
        sweep_reads();
        check_retired();
        finish_test();

        $display("tests run %0d, tests failed %0d, checks failed %0d",
                 tests_run, tests_failed, total_errs);
        if (total_errs == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: filelist.f
+incdir+hdl
hdl/wb_pkg.sv
hdl/wb_if.sv
hdl/mem_wb_stage.sv
hdl/wb_select.sv
hdl/gpr_file.sv
hdl/csr_file.sv
hdl/wb_subsystem.sv
dv/tb_wb_subsystem.sv

// File: hdl/csr_file.sv
`include "wb_defs.svh"

module csr_file (
    input  logic              clk,
    input  logic              rst_n,

    // two write requests from the selector
    csr_write_if.dst          wr,

    // read port
    input  wb_pkg::csr_addr_t raddr,
    output wb_pkg::xlen_t     rdata
);

    import wb_pkg::*;

    localparam int          N_CSR    = 5;
    // index for an address outside the map
    localparam logic [2:0]  IDX_NONE = 3'd5;

    xlen_t      csr_q [N_CSR];
    logic [2:0] idx_1;
    logic [2:0] idx_2;
    logic [2:0] idx_r;

    // ==================================================================
    // address decode
    // ==================================================================
    function automatic logic [2:0] csr_index(input csr_addr_t addr);
        logic [2:0] idx;
        case (addr)
            `WB_CSR_MSTATUS:  idx = 3'd0;
            `WB_CSR_MTVEC:    idx = 3'd1;
            `WB_CSR_MSCRATCH: idx = 3'd2;
            `WB_CSR_MEPC:     idx = 3'd3;
            `WB_CSR_MCAUSE:   idx = 3'd4;
            default:          idx = IDX_NONE;
        endcase
        return idx;
    endfunction

    assign idx_1 = csr_index(wr.addr_1);
    assign idx_2 = csr_index(wr.addr_2);
    assign idx_r = csr_index(raddr);

    // ==================================================================
    // storage
    // ==================================================================
    // port 2 wins on a shared target, unmapped writes fall through
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < N_CSR; i++) begin
                csr_q[i] <= '0;
            end
        end else begin
            for (int i = 0; i < N_CSR; i++) begin
                if (wr.we_2 && idx_2 == 3'(i)) begin
                    csr_q[i] <= wr.data_2;
                end else if (wr.we_1 && idx_1 == 3'(i)) begin
                    csr_q[i] <= wr.data_1;
                end
            end
        end
    end

    // ==================================================================
    // read with forwarding
    // ==================================================================
    always_comb begin
        if (idx_r == IDX_NONE) begin
            rdata = '0;
        end else if (wr.we_2 && wr.addr_2 == raddr) begin
            rdata = wr.data_2;
        end else if (wr.we_1 && wr.addr_1 == raddr) begin
            rdata = wr.data_1;
        end else begin
            rdata = csr_q[idx_r];
        end
    end

endmodule

// File: hdl/gpr_file.sv
module gpr_file (
    input  logic              clk,
    input  logic              rst_n,

    // write port
    input  logic              we,
    input  wb_pkg::gpr_addr_t waddr,
    input  wb_pkg::xlen_t     wdata,

    // read ports
    input  wb_pkg::gpr_addr_t rs1_addr,
    input  wb_pkg::gpr_addr_t rs2_addr,
    output wb_pkg::xlen_t     rs1_data,
    output wb_pkg::xlen_t     rs2_data
);

    import wb_pkg::*;

    // x0 has no storage
    xlen_t regs [1:31];

    // ==================================================================
    // write side
    // ==================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    // ==================================================================
    // read side
    // ==================================================================
    // same-cycle write is forwarded, x0 always zero
    function automatic xlen_t read_port(input gpr_addr_t addr);
        xlen_t data;
        if (addr == '0) begin
            data = '0;
        end else if (we && waddr == addr) begin
            data = wdata;
        end else begin
            data = regs[addr];
        end
        return data;
    endfunction

    always_comb begin
        rs1_data = read_port(rs1_addr);
        rs2_data = read_port(rs2_addr);
    end

endmodule

// File: hdl/mem_wb_stage.sv
module mem_wb_stage (
    input  logic               clk,
    input  logic               rst_n,

    // bundle from the memory stage
    input  logic               in_valid,
    input  wb_pkg::wb_bundle_t in_bundle,

    // registered bundle towards the selector
    wb_stage_if.stage          wb
);

    import wb_pkg::*;

    logic       valid_q;
    wb_bundle_t bundle_q;

    // ==================================================================
    // valid bit
    // ==================================================================
    // high for exactly one cycle after each strobe
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= in_valid;
        end
    end

    // ==================================================================
    // payload
    // ==================================================================
    // captured on a strobe, otherwise the last bundle stays put
    always_ff @(posedge clk) begin
        if (in_valid) begin
            bundle_q <= in_bundle;
        end
    end

    assign wb.valid  = valid_q;
    assign wb.bundle = bundle_q;

endmodule

// File: hdl/wb_defs.svh
`ifndef WB_DEFS_SVH
`define WB_DEFS_SVH

// datapath widths
`define WB_XLEN   32
`define WB_INST_W 32
`define WB_GPR_W  5
`define WB_CSR_W  12

// ======================================================================
// machine mode csr addresses
// ======================================================================
`define WB_CSR_MSTATUS  12'h300
`define WB_CSR_MTVEC    12'h305
`define WB_CSR_MSCRATCH 12'h340
`define WB_CSR_MEPC     12'h341
`define WB_CSR_MCAUSE   12'h342

`endif

// File: hdl/wb_if.sv
// stage register to selector
interface wb_stage_if;

    import wb_pkg::*;

    logic       valid;
    wb_bundle_t bundle;

    modport stage (
        output valid,
        output bundle
    );

    modport sel (
        input valid,
        input bundle
    );

endinterface

// two csr write requests per retiring instruction
interface csr_write_if;

    import wb_pkg::*;

    // port 1 carries the csr instruction result
    logic      we_1;
    csr_addr_t addr_1;
    xlen_t     data_1;

    // port 2 carries the epc save, higher priority
    logic      we_2;
    csr_addr_t addr_2;
    xlen_t     data_2;

    modport src (
        output we_1, addr_1, data_1,
        output we_2, addr_2, data_2
    );

    modport dst (
        input we_1, addr_1, data_1,
        input we_2, addr_2, data_2
    );

endinterface

// File: hdl/wb_pkg.sv
`include "wb_defs.svh"

package wb_pkg;

    // scalar types of the write-back datapath
    typedef logic [`WB_XLEN-1:0]  xlen_t;
    typedef logic [`WB_INST_W-1:0] inst_t;
    typedef logic [`WB_GPR_W-1:0]  gpr_addr_t;
    typedef logic [`WB_CSR_W-1:0]  csr_addr_t;

    // ==================================================================
    // bundle handed over from the memory stage
    // ==================================================================
    typedef struct packed {
        // instruction identity
        xlen_t     pc;
        inst_t     inst;

        // candidate write data
        xlen_t     alu_out;
        xlen_t     csr_out;
        xlen_t     rdata;

        // write controls
        logic      write_gpr;
        logic      write_csr_1;
        logic      write_csr_2;
        logic      mem_to_reg;

        // destinations
        gpr_addr_t rd;
        csr_addr_t csr_rd_1;
        csr_addr_t csr_rd_2;

        // stop the core after this one retires
        logic      halt;
    } wb_bundle_t;

endpackage

// File: hdl/wb_select.sv
module wb_select (
    input  logic              clk,
    input  logic              rst_n,

    // registered bundle
    wb_stage_if.sel           wb,

    // general register write
    output logic              gpr_we,
    output wb_pkg::gpr_addr_t gpr_waddr,
    output wb_pkg::xlen_t     gpr_wdata,

    // csr write requests
    csr_write_if.src          csr_wr,

    // retire status
    output logic              commit,
    output wb_pkg::xlen_t     commit_pc,
    output wb_pkg::inst_t     commit_inst,
    output logic              halted,
    output logic [63:0]       instret
);

    import wb_pkg::*;

    wb_bundle_t b;

    assign b = wb.bundle;

    // nothing retires once the core has halted
    assign commit      = wb.valid && !halted;
    assign commit_pc   = b.pc;
    assign commit_inst = b.inst;

    // ==================================================================
    // write data selection
    // ==================================================================
    // load data or alu result
    assign gpr_wdata = b.mem_to_reg ? b.rdata : b.alu_out;
    assign gpr_waddr = b.rd;
    assign gpr_we    = commit && b.write_gpr;

    // port 1 takes the csr result
    assign csr_wr.we_1   = commit && b.write_csr_1;
    assign csr_wr.addr_1 = b.csr_rd_1;
    assign csr_wr.data_1 = b.csr_out;

    // port 2 saves the pc, as mepc for a trap-style instruction
    assign csr_wr.we_2   = commit && b.write_csr_2;
    assign csr_wr.addr_2 = b.csr_rd_2;
    assign csr_wr.data_2 = b.pc;

    // ==================================================================
    // retire counter and halt latch
    // ==================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            instret <= 64'd0;
            halted  <= 1'b0;
        end else if (commit) begin
            instret <= instret + 64'd1;
            // sticky until reset, the halting item itself still counts
            if (b.halt) begin
                halted <= 1'b1;
            end
        end
    end

endmodule

// File: hdl/wb_subsystem.sv
module wb_subsystem (
    input  logic              clk,
    input  logic              rst_n,

    // incoming bundle, qualified by in_valid
    input  logic              in_valid,
    input  wb_pkg::xlen_t     in_pc,
    input  wb_pkg::inst_t     in_inst,
    input  wb_pkg::xlen_t     in_alu_out,
    input  wb_pkg::xlen_t     in_csr_out,
    input  wb_pkg::xlen_t     in_rdata,
    input  logic              in_write_gpr,
    input  logic              in_write_csr_1,
    input  logic              in_write_csr_2,
    input  logic              in_mem_to_reg,
    input  wb_pkg::gpr_addr_t in_rd,
    input  wb_pkg::csr_addr_t in_csr_rd_1,
    input  wb_pkg::csr_addr_t in_csr_rd_2,
    input  logic              in_halt,

    // read addresses
    input  wb_pkg::gpr_addr_t rs1_addr,
    input  wb_pkg::gpr_addr_t rs2_addr,
    input  wb_pkg::csr_addr_t csr_raddr,

    // read data
    output wb_pkg::xlen_t     rs1_data,
    output wb_pkg::xlen_t     rs2_data,
    output wb_pkg::xlen_t     csr_rdata,

    // retire status
    output logic              commit,
    output wb_pkg::xlen_t     commit_pc,
    output wb_pkg::inst_t     commit_inst,
    output logic              halted,
    output logic [63:0]       instret
);

    import wb_pkg::*;

    wb_bundle_t in_bundle;
    logic       gpr_we;
    gpr_addr_t  gpr_waddr;
    xlen_t      gpr_wdata;

    wb_stage_if  wb_stage ();
    csr_write_if csr_wr ();

    // pack the plain inputs
    assign in_bundle = '{
        pc:          in_pc,
        inst:        in_inst,
        alu_out:     in_alu_out,
        csr_out:     in_csr_out,
        rdata:       in_rdata,
        write_gpr:   in_write_gpr,
        write_csr_1: in_write_csr_1,
        write_csr_2: in_write_csr_2,
        mem_to_reg:  in_mem_to_reg,
        rd:          in_rd,
        csr_rd_1:    in_csr_rd_1,
        csr_rd_2:    in_csr_rd_2,
        halt:        in_halt
    };

    // ==================================================================
    // write-back blocks
    // ==================================================================
    mem_wb_stage u_stage (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_bundle (in_bundle),
        .wb        (wb_stage)
    );

    wb_select u_select (
        .clk         (clk),
        .rst_n       (rst_n),
        .wb          (wb_stage),
        .gpr_we      (gpr_we),
        .gpr_waddr   (gpr_waddr),
        .gpr_wdata   (gpr_wdata),
        .csr_wr      (csr_wr),
        .commit      (commit),
        .commit_pc   (commit_pc),
        .commit_inst (commit_inst),
        .halted      (halted),
        .instret     (instret)
    );

    gpr_file u_gpr (
        .clk      (clk),
        .rst_n    (rst_n),
        .we       (gpr_we),
        .waddr    (gpr_waddr),
        .wdata    (gpr_wdata),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    csr_file u_csr (
        .clk   (clk),
        .rst_n (rst_n),
        .wr    (csr_wr),
        .raddr (csr_raddr),
        .rdata (csr_rdata)
    );

endmodule

// File: run_sim.sh
#!/bin/sh
# build the write-back testbench with Verilator, run it, and judge the log
cd "$(dirname "$0")" || exit 1

rm -f sim.log &&
verilator --binary --timing --assert -Wno-fatal -f filelist.f \
    --top-module tb_wb_subsystem -o sim_wb > build.log 2>&1 &&
./obj_dir/sim_wb > sim.log 2>&1

grep -q "^TEST RESULT: PASS$" sim.log && echo "simulation passed" ||
{ echo "simulation failed, see build.log and sim.log"; exit 1; }
